//--- lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// bit counter for 32 serial cycles
`define LSU_CNT_W 5

// ram word address bits, 256 words
`define RAM_AW 8

// request buffer entries
`define REQBUF_DEPTH 2

`endif

//--- lsu_pkg.sv
package lsu_pkg;

   // request opcode from the core side
   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   // access width and signedness, risc-v funct3 encodings
   typedef enum logic [2:0] {
      F3_B  = 3'b000,
      F3_H  = 3'b001,
      F3_W  = 3'b010,
      F3_BU = 3'b100,
      F3_HU = 3'b101
   } funct3_e;

   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_INIT,
      SEQ_WAIT,
      SEQ_RESULT,
      SEQ_DONE
   } seq_state_e;

endpackage

//--- mem_pkg.sv
package mem_pkg;

   // command on the memory bus
   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_cmd_e;

   // ram read data is held until the read channel takes it
   typedef enum logic {
      RAM_IDLE      = 1'b0,
      RAM_READ_HOLD = 1'b1
   } ram_state_e;

endpackage

//--- lsu_sequencer.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_sequencer (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_req_valid,
   input  lsu_pkg::lsu_op_e      i_req_op,
   input  lsu_pkg::funct3_e      i_req_funct3,
   input  logic [`LSU_XLEN-1:0]  i_req_base,
   input  logic [`LSU_XLEN-1:0]  i_req_offset,
   input  logic [`LSU_XLEN-1:0]  i_req_wdata,
   input  logic                  i_rd,
   input  logic                  i_busy,
   output logic                  o_req_ready,
   output logic                  o_rsp_valid,
   output logic [`LSU_XLEN-1:0]  o_rsp_rdata,
   output logic                  o_en,
   output logic                  o_init,
   output logic                  o_dat_valid,
   output logic                  o_cmd,
   output lsu_pkg::funct3_e      o_funct3,
   output logic                  o_rs1,
   output logic                  o_rs2,
   output logic                  o_imm
);

   lsu_pkg::seq_state_e         state;
   logic [`LSU_CNT_W-1:0]       cnt;
   lsu_pkg::lsu_op_e            op_r;
   lsu_pkg::funct3_e            f3_r;
   logic [`LSU_XLEN-1:0]        rs1_sr;
   logic [`LSU_XLEN-1:0]        imm_sr;
   logic [`LSU_XLEN-1:0]        rs2_sr;
   logic [2:0]                  f3_bits;
   logic                        accept;
   logic                        last_bit;

   assign accept   = i_req_valid & o_req_ready;
   assign last_bit = (cnt == {`LSU_CNT_W{1'b1}});
   assign f3_bits  = f3_r;

   assign o_req_ready = (state == lsu_pkg::SEQ_IDLE);
   assign o_rsp_valid = (state == lsu_pkg::SEQ_DONE);
   assign o_init      = (state == lsu_pkg::SEQ_INIT);
   assign o_en        = (state == lsu_pkg::SEQ_INIT) | (state == lsu_pkg::SEQ_RESULT);
   assign o_cmd       = (op_r == lsu_pkg::LSU_STORE);
   assign o_funct3    = f3_r;

   // operands go out lsb first
   assign o_rs1 = rs1_sr[0];
   assign o_imm = imm_sr[0];
   assign o_rs2 = rs2_sr[0];

   // load bits are only meaningful for the access width
   always_comb begin
      o_dat_valid = 1'b0;
      if (state == lsu_pkg::SEQ_RESULT) begin
         case (f3_bits[1:0])
            2'b00:   o_dat_valid = (cnt < `LSU_CNT_W'(8));
            2'b01:   o_dat_valid = (cnt < `LSU_CNT_W'(16));
            default: o_dat_valid = 1'b1;
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= lsu_pkg::SEQ_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            lsu_pkg::SEQ_IDLE: begin
               cnt <= '0;
               if (accept)
                  state <= lsu_pkg::SEQ_INIT;
            end
            lsu_pkg::SEQ_INIT: begin
               cnt <= cnt + 1'b1;
               if (last_bit)
                  state <= lsu_pkg::SEQ_WAIT;
            end
            lsu_pkg::SEQ_WAIT: begin
               if (!i_busy)
                  state <= (op_r == lsu_pkg::LSU_LOAD) ? lsu_pkg::SEQ_RESULT
                                                       : lsu_pkg::SEQ_DONE;
            end
            lsu_pkg::SEQ_RESULT: begin
               cnt <= cnt + 1'b1;
               if (last_bit)
                  state <= lsu_pkg::SEQ_DONE;
            end
            default: state <= lsu_pkg::SEQ_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         op_r        <= i_req_op;
         f3_r        <= i_req_funct3;
         rs1_sr      <= i_req_base;
         imm_sr      <= i_req_offset;
         rs2_sr      <= i_req_wdata;
         o_rsp_rdata <= '0;
      end else if (state == lsu_pkg::SEQ_INIT) begin
         rs1_sr <= {1'b0, rs1_sr[`LSU_XLEN-1:1]};
         imm_sr <= {1'b0, imm_sr[`LSU_XLEN-1:1]};
         rs2_sr <= {1'b0, rs2_sr[`LSU_XLEN-1:1]};
      end else if (state == lsu_pkg::SEQ_RESULT) begin
         o_rsp_rdata <= {i_rd, o_rsp_rdata[`LSU_XLEN-1:1]};
      end
   end

   // init is one serial word long
   a_init_32_cycles: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $fell(o_init) |-> ($past(o_init, 32) & !$past(o_init, 33)));

endmodule

//--- serial_mem_if.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module serial_mem_if (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_en,
   input  logic                  i_init,
   input  logic                  i_dat_valid,
   input  logic                  i_cmd,
   input  lsu_pkg::funct3_e      i_funct3,
   input  logic                  i_rs1,
   input  logic                  i_rs2,
   input  logic                  i_imm,
   input  logic                  i_ca_rdy,
   input  logic                  i_dm_rdy,
   input  logic [`LSU_XLEN-1:0]  i_rd_dat,
   input  logic                  i_rd_vld,
   output logic                  o_rd,
   output logic                  o_busy,
   output mem_pkg::mem_cmd_e     o_ca_cmd,
   output logic [`LSU_XLEN-1:0]  o_ca_adr,
   output logic                  o_ca_vld,
   output logic [`LSU_XLEN-1:0]  o_dm_dat,
   output logic [3:0]            o_dm_msk,
   output logic                  o_dm_vld,
   output logic                  o_rd_rdy
);

   logic [2:0]                 f3;
   logic                       is_signed;
   logic                       is_word;
   logic                       is_half;
   logic                       is_byte;
   logic                       upper_half;
   logic                       ca_en;
   logic                       dm_en;
   logic                       rd_en;
   logic                       sum;
   logic                       carry;
   logic [`LSU_XLEN-1:0]       adr_sr;
   logic [`LSU_XLEN-1:0]       dat;
   logic [1:0]                 bytepos;
   logic [`LSU_CNT_W-1:0]      cnt;
   logic                       init_r;
   logic                       init_2r;
   logic                       init_fall;
   logic                       signbit;
   logic                       dat_en;

   assign f3         = i_funct3;
   assign is_signed  = ~f3[2];
   assign is_word    = f3[1];
   assign is_half    = f3[0];
   assign is_byte    = ~(|f3[1:0]);
   assign upper_half = bytepos[1];

   assign ca_en     = o_ca_vld & i_ca_rdy;
   assign dm_en     = o_dm_vld & i_dm_rdy;
   assign rd_en     = i_rd_vld & o_rd_rdy;
   assign init_fall = init_r & ~i_init;

   // read data is only taken between serial phases
   assign o_rd_rdy = ~i_en;

   // serial rs1 + imm, one bit per cycle
   assign sum = i_rs1 ^ i_imm ^ carry;

   assign o_ca_adr = adr_sr;
   assign o_ca_cmd = mem_pkg::mem_cmd_e'(i_cmd);
   assign o_dm_dat = dat;

   // past the access width the load is extended with the held sign bit
   assign o_rd = i_dat_valid ? dat[0] : (signbit & is_signed);

   // stop shifting store data once it reaches its byte lane
   always_comb begin
      if (is_word)
         dat_en = 1'b1;
      else if (is_half)
         dat_en = upper_half ? (cnt < `LSU_CNT_W'(16)) : 1'b1;
      else begin
         case (bytepos)
            2'd3:    dat_en = (cnt < `LSU_CNT_W'(8));
            2'd2:    dat_en = (cnt < `LSU_CNT_W'(16));
            2'd1:    dat_en = (cnt < `LSU_CNT_W'(24));
            default: dat_en = 1'b1;
         endcase
      end
   end

   always_comb begin
      if (is_word)
         o_dm_msk = 4'b1111;
      else if (is_half)
         o_dm_msk = upper_half ? 4'b1100 : 4'b0011;
      else
         o_dm_msk = 4'b0001 << bytepos;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry    <= 1'b0;
         cnt      <= '0;
         init_r   <= 1'b0;
         init_2r  <= 1'b0;
         o_busy   <= 1'b0;
         o_ca_vld <= 1'b0;
         o_dm_vld <= 1'b0;
      end else begin
         carry   <= i_en & ((i_rs1 & i_imm) | (carry & (i_rs1 ^ i_imm)));
         cnt     <= cnt + `LSU_CNT_W'(i_init);
         init_r  <= i_init;
         init_2r <= init_r;

         if (i_en & i_init)
            o_busy <= 1'b1;
         else if (rd_en | dm_en)
            o_busy <= 1'b0;

         if (ca_en)
            o_ca_vld <= 1'b0;
         else if (init_fall)
            o_ca_vld <= 1'b1;

         if (dm_en)
            o_dm_vld <= 1'b0;
         else if (init_fall)
            o_dm_vld <= i_cmd;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_init)
         adr_sr <= {sum, adr_sr[`LSU_XLEN-1:1]};

      // address bits 0 and 1 come out in the first two init cycles
      if (i_init & ~init_r)
         bytepos[0] <= sum;
      if (init_r & ~init_2r)
         bytepos[1] <= sum;

      if (i_dat_valid)
         signbit <= dat[0];

      // move the addressed lane down to bit 0
      if (rd_en) begin
         dat[31:16] <= i_rd_dat[31:16];
         dat[15:8]  <= (is_half & upper_half) ? i_rd_dat[31:24] : i_rd_dat[15:8];
         if (is_byte & (bytepos == 2'd3))
            dat[7:0] <= i_rd_dat[31:24];
         else if ((is_byte & (bytepos == 2'd2)) | (is_half & upper_half))
            dat[7:0] <= i_rd_dat[23:16];
         else if (is_byte & (bytepos == 2'd1))
            dat[7:0] <= i_rd_dat[15:8];
         else
            dat[7:0] <= i_rd_dat[7:0];
      end else if (i_en & dat_en) begin
         dat <= {i_rs2, dat[`LSU_XLEN-1:1]};
      end
   end

   // a stalled request keeps its payload
   a_ca_vld_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_ca_vld & ~i_ca_rdy) |=> (o_ca_vld & $stable(o_ca_adr) & $stable(o_ca_cmd)));

   a_dm_vld_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_dm_vld & ~i_dm_rdy) |=> (o_dm_vld & $stable(o_dm_dat) & $stable(o_dm_msk)));

   a_dm_not_on_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(o_dm_vld) |-> (o_ca_cmd == mem_pkg::MEM_WRITE));

endmodule

//--- mem_req_buffer.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module mem_req_buffer #(
   parameter int DEPTH = `REQBUF_DEPTH
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  mem_pkg::mem_cmd_e     i_ca_cmd,
   input  logic [`LSU_XLEN-1:0]  i_ca_adr,
   input  logic                  i_ca_vld,
   input  logic [`LSU_XLEN-1:0]  i_dm_dat,
   input  logic [3:0]            i_dm_msk,
   input  logic                  i_dm_vld,
   input  logic                  i_req_rdy,
   output logic                  o_ca_rdy,
   output logic                  o_dm_rdy,
   output mem_pkg::mem_cmd_e     o_req_cmd,
   output logic [`LSU_XLEN-1:0]  o_req_adr,
   output logic [`LSU_XLEN-1:0]  o_req_dat,
   output logic [3:0]            o_req_msk,
   output logic                  o_req_vld
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   mem_pkg::mem_cmd_e           cmd_q [DEPTH];
   logic [`LSU_XLEN-1:0]        adr_q [DEPTH];
   logic [`LSU_XLEN-1:0]        dat_q [DEPTH];
   logic [3:0]                  msk_q [DEPTH];
   logic [PW-1:0]               wr_ptr;
   logic [PW-1:0]               rd_ptr;
   logic [CW-1:0]               count;
   logic                        full;
   logic                        push;
   logic                        pop;

   assign full     = (count == CW'(DEPTH));
   assign o_ca_rdy = ~full;
   assign o_dm_rdy = ~full;

   // a write needs its data beat in the same cycle as the command
   assign push = i_ca_vld & o_ca_rdy & ((i_ca_cmd == mem_pkg::MEM_READ) | i_dm_vld);
   assign pop  = o_req_vld & i_req_rdy;

   assign o_req_vld = (count != '0);
   assign o_req_cmd = cmd_q[rd_ptr];
   assign o_req_adr = adr_q[rd_ptr];
   assign o_req_dat = dat_q[rd_ptr];
   assign o_req_msk = msk_q[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (push) begin
         cmd_q[wr_ptr] <= i_ca_cmd;
         adr_q[wr_ptr] <= i_ca_adr;
         dat_q[wr_ptr] <= i_dm_dat;
         msk_q[wr_ptr] <= i_dm_msk;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CW'(push) - CW'(pop);
      end
   end

   // pointers meet only when the queue is empty or full
   a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      push |-> ((wr_ptr != rd_ptr) | (count == '0)));

   a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      pop |-> ((wr_ptr != rd_ptr) | full));

endmodule

//--- data_ram.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module data_ram #(
   parameter int DEPTH_LOG2 = `RAM_AW
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  mem_pkg::mem_cmd_e     i_req_cmd,
   input  logic [`LSU_XLEN-1:0]  i_req_adr,
   input  logic [`LSU_XLEN-1:0]  i_req_dat,
   input  logic [3:0]            i_req_msk,
   input  logic                  i_req_vld,
   input  logic                  i_rd_rdy,
   output logic                  o_req_rdy,
   output logic [`LSU_XLEN-1:0]  o_rd_dat,
   output logic                  o_rd_vld
);

   logic [`LSU_XLEN-1:0]        mem [2**DEPTH_LOG2];
   mem_pkg::ram_state_e         state;
   logic [DEPTH_LOG2-1:0]       word_idx;
   logic                        req_en;

   assign word_idx  = i_req_adr[DEPTH_LOG2+1:2];
   assign req_en    = i_req_vld & o_req_rdy;
   assign o_req_rdy = (state == mem_pkg::RAM_IDLE);
   assign o_rd_vld  = (state == mem_pkg::RAM_READ_HOLD);

   always_ff @(posedge i_clk) begin
      if (req_en) begin
         if (i_req_cmd == mem_pkg::MEM_WRITE) begin
            for (int b = 0; b < 4; b++) begin
               if (i_req_msk[b])
                  mem[word_idx][8*b +: 8] <= i_req_dat[8*b +: 8];
            end
         end else begin
            o_rd_dat <= mem[word_idx];
         end
      end
   end

   // a read blocks new requests until its data is taken
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         state <= mem_pkg::RAM_IDLE;
      else if (req_en & (i_req_cmd == mem_pkg::MEM_READ))
         state <= mem_pkg::RAM_READ_HOLD;
      else if (o_rd_vld & i_rd_rdy)
         state <= mem_pkg::RAM_IDLE;
   end

   a_adr_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_req_vld |-> (i_req_adr[`LSU_XLEN-1:DEPTH_LOG2+2] == '0));

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_req_valid,
   output logic                  o_req_ready,
   input  lsu_pkg::lsu_op_e      i_req_op,
   input  lsu_pkg::funct3_e      i_req_funct3,
   input  logic [`LSU_XLEN-1:0]  i_req_base,
   input  logic [`LSU_XLEN-1:0]  i_req_offset,
   input  logic [`LSU_XLEN-1:0]  i_req_wdata,
   output logic                  o_rsp_valid,
   output logic [`LSU_XLEN-1:0]  o_rsp_rdata
);

   logic                        en;
   logic                        init;
   logic                        dat_valid;
   logic                        cmd;
   lsu_pkg::funct3_e            funct3;
   logic                        rs1;
   logic                        rs2;
   logic                        imm;
   logic                        rd;
   logic                        busy;
   mem_pkg::mem_cmd_e           ca_cmd;
   logic [`LSU_XLEN-1:0]        ca_adr;
   logic                        ca_vld;
   logic                        ca_rdy;
   logic [`LSU_XLEN-1:0]        dm_dat;
   logic [3:0]                  dm_msk;
   logic                        dm_vld;
   logic                        dm_rdy;
   mem_pkg::mem_cmd_e           req_cmd;
   logic [`LSU_XLEN-1:0]        req_adr;
   logic [`LSU_XLEN-1:0]        req_dat;
   logic [3:0]                  req_msk;
   logic                        req_vld;
   logic                        req_rdy;
   logic [`LSU_XLEN-1:0]        rd_dat;
   logic                        rd_vld;
   logic                        rd_rdy;

   lsu_sequencer u_sequencer (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_req_valid  (i_req_valid),
      .i_req_op     (i_req_op),
      .i_req_funct3 (i_req_funct3),
      .i_req_base   (i_req_base),
      .i_req_offset (i_req_offset),
      .i_req_wdata  (i_req_wdata),
      .i_rd         (rd),
      .i_busy       (busy),
      .o_req_ready  (o_req_ready),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp_rdata  (o_rsp_rdata),
      .o_en         (en),
      .o_init       (init),
      .o_dat_valid  (dat_valid),
      .o_cmd        (cmd),
      .o_funct3     (funct3),
      .o_rs1        (rs1),
      .o_rs2        (rs2),
      .o_imm        (imm)
   );

   serial_mem_if u_mem_if (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_en        (en),
      .i_init      (init),
      .i_dat_valid (dat_valid),
      .i_cmd       (cmd),
      .i_funct3    (funct3),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .i_ca_rdy    (ca_rdy),
      .i_dm_rdy    (dm_rdy),
      .i_rd_dat    (rd_dat),
      .i_rd_vld    (rd_vld),
      .o_rd        (rd),
      .o_busy      (busy),
      .o_ca_cmd    (ca_cmd),
      .o_ca_adr    (ca_adr),
      .o_ca_vld    (ca_vld),
      .o_dm_dat    (dm_dat),
      .o_dm_msk    (dm_msk),
      .o_dm_vld    (dm_vld),
      .o_rd_rdy    (rd_rdy)
   );

   mem_req_buffer #(
      .DEPTH (`REQBUF_DEPTH)
   ) u_req_buf (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_ca_cmd  (ca_cmd),
      .i_ca_adr  (ca_adr),
      .i_ca_vld  (ca_vld),
      .i_dm_dat  (dm_dat),
      .i_dm_msk  (dm_msk),
      .i_dm_vld  (dm_vld),
      .i_req_rdy (req_rdy),
      .o_ca_rdy  (ca_rdy),
      .o_dm_rdy  (dm_rdy),
      .o_req_cmd (req_cmd),
      .o_req_adr (req_adr),
      .o_req_dat (req_dat),
      .o_req_msk (req_msk),
      .o_req_vld (req_vld)
   );

   data_ram #(
      .DEPTH_LOG2 (`RAM_AW)
   ) u_ram (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_req_cmd (req_cmd),
      .i_req_adr (req_adr),
      .i_req_dat (req_dat),
      .i_req_msk (req_msk),
      .i_req_vld (req_vld),
      .i_rd_rdy  (rd_rdy),
      .o_req_rdy (req_rdy),
      .o_rd_dat  (rd_dat),
      .o_rd_vld  (rd_vld)
   );

endmodule

//--- tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu_top;

   localparam int N_RANDOM       = 40;
   localparam int CYCLES_PER_REQ = 200;
   localparam logic [31:0] RAND_BASE = 32'h200;

   logic                  i_clk = 1'b0;
   logic                  i_rst_n;
   logic                  i_req_valid;
   lsu_pkg::lsu_op_e      i_req_op;
   lsu_pkg::funct3_e      i_req_funct3;
   logic [`LSU_XLEN-1:0]  i_req_base;
   logic [`LSU_XLEN-1:0]  i_req_offset;
   logic [`LSU_XLEN-1:0]  i_req_wdata;
   logic                  o_req_ready;
   logic                  o_rsp_valid;
   logic [`LSU_XLEN-1:0]  o_rsp_rdata;

   // stimulus table, one entry per index
   string                 name_q [$];
   lsu_pkg::lsu_op_e      op_q [$];
   lsu_pkg::funct3_e      f3_q [$];
   logic [31:0]           base_q [$];
   logic [31:0]           off_q [$];
   logic [31:0]           wdata_q [$];
   logic [31:0]           exp_q [$];

   // reference memory, word valid once fully written
   logic [31:0]           model_mem [2**`RAM_AW];
   logic                  model_vld [2**`RAM_AW];

   integer                seed = 32'hf31d48d7;
   int                    req_count = 0;
   int                    rsp_count = 0;
   logic                  table_ready = 1'b0;

   lsu_top lsu_top_i (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_req_valid  (i_req_valid),
      .o_req_ready  (o_req_ready),
      .i_req_op     (i_req_op),
      .i_req_funct3 (i_req_funct3),
      .i_req_base   (i_req_base),
      .i_req_offset (i_req_offset),
      .i_req_wdata  (i_req_wdata),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp_rdata  (o_rsp_rdata)
   );

   always #5 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      if (i_rst_n && o_rsp_valid)
         rsp_count <= rsp_count + 1;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch %s expected %h actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic add_case(input string name, input lsu_pkg::lsu_op_e op,
                           input lsu_pkg::funct3_e f3, input logic [31:0] base,
                           input logic [31:0] off, input logic [31:0] wdata,
                           input logic [31:0] expected);
      name_q.push_back(name);
      op_q.push_back(op);
      f3_q.push_back(f3);
      base_q.push_back(base);
      off_q.push_back(off);
      wdata_q.push_back(wdata);
      exp_q.push_back(expected);
   endtask

   function automatic void model_store(input logic [31:0] addr, input lsu_pkg::funct3_e f3,
                                       input logic [31:0] wdata);
      int idx;
      int lane;
      idx  = int'(addr[`RAM_AW+1:2]);
      lane = int'(addr[1:0]);
      case (f3)
         lsu_pkg::F3_B, lsu_pkg::F3_BU: model_mem[idx][8*lane +: 8] = wdata[7:0];
         lsu_pkg::F3_H, lsu_pkg::F3_HU: model_mem[idx][8*lane +: 16] = wdata[15:0];
         default: begin
            model_mem[idx] = wdata;
            model_vld[idx] = 1'b1;
         end
      endcase
   endfunction

   function automatic logic [31:0] model_load(input logic [31:0] addr,
                                              input lsu_pkg::funct3_e f3);
      logic [31:0] word;
      logic [7:0]  b;
      logic [15:0] h;
      word = model_mem[addr[`RAM_AW+1:2]];
      b    = 8'(word >> (8 * addr[1:0]));
      h    = addr[1] ? word[31:16] : word[15:0];
      case (f3)
         lsu_pkg::F3_B:  model_load = {{24{b[7]}}, b};
         lsu_pkg::F3_BU: model_load = {24'h0, b};
         lsu_pkg::F3_H:  model_load = {{16{h[15]}}, h};
         lsu_pkg::F3_HU: model_load = {16'h0, h};
         default:        model_load = word;
      endcase
   endfunction

   // one request from handshake to response, ready must stay low meanwhile
   task automatic apply_request(input string name, input lsu_pkg::lsu_op_e op,
                                input lsu_pkg::funct3_e f3, input logic [31:0] base,
                                input logic [31:0] off, input logic [31:0] wdata,
                                output logic [31:0] rdata);
      i_req_valid  = 1'b1;
      i_req_op     = op;
      i_req_funct3 = f3;
      i_req_base   = base;
      i_req_offset = off;
      i_req_wdata  = wdata;
      @(posedge i_clk);
      while (!o_req_ready)
         @(posedge i_clk);
      #1;
      i_req_valid = 1'b0;
      req_count   = req_count + 1;
      @(posedge i_clk);
      while (!o_rsp_valid) begin
         check_value({name, " ready busy"}, 32'd0, {31'd0, o_req_ready});
         @(posedge i_clk);
      end
      rdata = o_rsp_rdata;
      @(posedge i_clk);
      check_value({name, " single pulse"}, 32'd0, {31'd0, o_rsp_valid});
      #1;
   endtask

   task automatic build_table();
      // word access, positive and negative offsets
      add_case("sw_pos_off", lsu_pkg::LSU_STORE, lsu_pkg::F3_W, 32'h100, 32'h10,
               32'hdeadbeef, 32'h0);
      add_case("lw_neg_off", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h120, 32'hfffffff0,
               32'h0, 32'hdeadbeef);
      add_case("lw_zero_off", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h110, 32'h0,
               32'h0, 32'hdeadbeef);
      add_case("sw_a", lsu_pkg::LSU_STORE, lsu_pkg::F3_W, 32'h40, 32'h0, 32'h12f07f80, 32'h0);
      add_case("sw_b", lsu_pkg::LSU_STORE, lsu_pkg::F3_W, 32'h30, 32'h14, 32'h8d3ca55a, 32'h0);
      // sign and zero extension in every lane
      add_case("lb_a0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h40, 32'h0, 32'h0, 32'hffffff80);
      add_case("lb_a1", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h40, 32'h1, 32'h0, 32'h0000007f);
      add_case("lb_a2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h42, 32'h0, 32'h0, 32'hfffffff0);
      add_case("lb_a3", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h44, 32'hffffffff, 32'h0,
               32'h00000012);
      add_case("lbu_a0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_BU, 32'h40, 32'h0, 32'h0, 32'h80);
      add_case("lbu_a2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_BU, 32'h40, 32'h2, 32'h0, 32'hf0);
      add_case("lb_b0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h44, 32'h0, 32'h0, 32'h0000005a);
      add_case("lb_b1", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h44, 32'h1, 32'h0, 32'hffffffa5);
      add_case("lb_b2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h44, 32'h2, 32'h0, 32'h0000003c);
      add_case("lb_b3", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h44, 32'h3, 32'h0, 32'hffffff8d);
      add_case("lbu_b1", lsu_pkg::LSU_LOAD, lsu_pkg::F3_BU, 32'h45, 32'h0, 32'h0, 32'ha5);
      add_case("lbu_b3", lsu_pkg::LSU_LOAD, lsu_pkg::F3_BU, 32'h48, 32'hffffffff, 32'h0,
               32'h8d);
      add_case("lh_a0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_H, 32'h40, 32'h0, 32'h0, 32'h00007f80);
      add_case("lh_a2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_H, 32'h40, 32'h2, 32'h0, 32'h000012f0);
      add_case("lh_b0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_H, 32'h44, 32'h0, 32'h0, 32'hffffa55a);
      add_case("lh_b2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_H, 32'h44, 32'h2, 32'h0, 32'hffff8d3c);
      add_case("lhu_b0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_HU, 32'h44, 32'h0, 32'h0, 32'ha55a);
      add_case("lhu_b2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_HU, 32'h46, 32'h0, 32'h0, 32'h8d3c);
      // partial stores only touch their lanes
      add_case("sw_c", lsu_pkg::LSU_STORE, lsu_pkg::F3_W, 32'h80, 32'h0, 32'h11223344, 32'h0);
      add_case("sb_c1", lsu_pkg::LSU_STORE, lsu_pkg::F3_B, 32'h80, 32'h1, 32'h555555ab, 32'h0);
      add_case("lw_c1", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h80, 32'h0, 32'h0, 32'h1122ab44);
      add_case("sh_c2", lsu_pkg::LSU_STORE, lsu_pkg::F3_H, 32'h80, 32'h2, 32'h9999cdef, 32'h0);
      add_case("lw_c2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h80, 32'h0, 32'h0, 32'hcdefab44);
      add_case("sw_d", lsu_pkg::LSU_STORE, lsu_pkg::F3_W, 32'h84, 32'h0, 32'ha5a5a5a5, 32'h0);
      add_case("sh_d0", lsu_pkg::LSU_STORE, lsu_pkg::F3_H, 32'h84, 32'h0, 32'h00001234, 32'h0);
      add_case("sb_d3", lsu_pkg::LSU_STORE, lsu_pkg::F3_B, 32'h84, 32'h3, 32'h00000077, 32'h0);
      add_case("lw_d", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h84, 32'h0, 32'h0, 32'h77a51234);
      add_case("sb_d0", lsu_pkg::LSU_STORE, lsu_pkg::F3_B, 32'h88, 32'hfffffffc, 32'hffffff00,
               32'h0);
      add_case("lh_d0", lsu_pkg::LSU_LOAD, lsu_pkg::F3_H, 32'h84, 32'h0, 32'h0, 32'h00001200);
      add_case("lb_d3", lsu_pkg::LSU_LOAD, lsu_pkg::F3_B, 32'h84, 32'h3, 32'h0, 32'h00000077);
      add_case("lw_d2", lsu_pkg::LSU_LOAD, lsu_pkg::F3_W, 32'h84, 32'h0, 32'h0, 32'h77a51200);
   endtask

   initial begin
      wait (table_ready);
      repeat (20 + (name_q.size() + N_RANDOM) * CYCLES_PER_REQ) @(posedge i_clk);
      $display("Timeout: the run did not finish in the allowed number of cycles");
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0]      rdata;
      logic [31:0]      r;
      logic [31:0]      r2;
      logic [31:0]      addr;
      logic [31:0]      off;
      logic [31:0]      expected;
      logic [3:0]       widx;
      logic [1:0]       lane;
      lsu_pkg::lsu_op_e op;
      lsu_pkg::funct3_e f3;

      i_rst_n      = 1'b0;
      i_req_valid  = 1'b0;
      i_req_op     = lsu_pkg::LSU_LOAD;
      i_req_funct3 = lsu_pkg::F3_W;
      i_req_base   = '0;
      i_req_offset = '0;
      i_req_wdata  = '0;
      for (int i = 0; i < 2**`RAM_AW; i++)
         model_vld[i] = 1'b0;
      build_table();
      table_ready = 1'b1;

      repeat (10) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      @(posedge i_clk);
      check_value("reset ready", 32'd1, {31'd0, o_req_ready});
      check_value("reset rsp_valid", 32'd0, {31'd0, o_rsp_valid});
      #1;

      for (int i = 0; i < name_q.size(); i++) begin
         apply_request(name_q[i], op_q[i], f3_q[i], base_q[i], off_q[i], wdata_q[i], rdata);
         check_value(name_q[i], exp_q[i], rdata);
         if (op_q[i] == lsu_pkg::LSU_STORE)
            model_store(base_q[i] + off_q[i], f3_q[i], wdata_q[i]);
      end

      // random aligned accesses inside a 16 word window
      for (int i = 0; i < N_RANDOM; i++) begin
         r    = $random(seed);
         r2   = $random(seed);
         widx = r[13:10];
         addr = RAND_BASE + (32'(widx) << 2);
         if (!model_vld[addr[`RAM_AW+1:2]]) begin
            op = lsu_pkg::LSU_STORE;
            f3 = lsu_pkg::F3_W;
         end else begin
            op = r[0] ? lsu_pkg::LSU_STORE : lsu_pkg::LSU_LOAD;
            case (r[4:2] % 5)
               0:       f3 = lsu_pkg::F3_B;
               1:       f3 = lsu_pkg::F3_H;
               2:       f3 = lsu_pkg::F3_W;
               3:       f3 = lsu_pkg::F3_BU;
               default: f3 = lsu_pkg::F3_HU;
            endcase
            if (op == lsu_pkg::LSU_STORE && f3 == lsu_pkg::F3_BU)
               f3 = lsu_pkg::F3_B;
            if (op == lsu_pkg::LSU_STORE && f3 == lsu_pkg::F3_HU)
               f3 = lsu_pkg::F3_H;
         end
         if (f3 == lsu_pkg::F3_W)
            lane = 2'd0;
         else if (f3 == lsu_pkg::F3_H || f3 == lsu_pkg::F3_HU)
            lane = {r[9], 1'b0};
         else
            lane = r[9:8];
         addr     = addr + 32'(lane);
         off      = {{20{r2[11]}}, r2[11:0]};
         expected = (op == lsu_pkg::LSU_STORE) ? 32'h0 : model_load(addr, f3);
         apply_request($sformatf("rand_%0d", i), op, f3, addr - off, off, r2 ^ r, rdata);
         check_value($sformatf("rand_%0d", i), expected, rdata);
         if (op == lsu_pkg::LSU_STORE)
            model_store(addr, f3, r2 ^ r);
      end

      @(posedge i_clk);
      #1;
      if (rsp_count == req_count) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Response count %0d does not match request count %0d", rsp_count, req_count);
         $display("Test failed");
         $fatal(1, "response count error");
      end
   end

endmodule

//--- flist.f
+incdir+.
lsu_pkg.sv
mem_pkg.sv
lsu_sequencer.sv
serial_mem_if.sv
mem_req_buffer.sv
data_ram.sv
lsu_top.sv
tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+1 +verilator+rand+reset+2
VFLAGS    ?= --binary --timing --assert --x-assign unique --x-initial unique -Wno-fatal

SOURCES := $(shell grep -v '^+' flist.f) lsu_consts.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED_ARGS BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): flist.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f flist.f

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
